// ==== common/l3c_pkg.sv ====
/*
 * Shared types for the last-level cache slice
 * Word and byte address vectors
 * Upstream request and memory burst command structs
 * Controller state encoding
 */
package l3c_pkg;

	// One data word on both the upstream and the memory side
	typedef logic [31:0] word_t;

	// Byte address, word aligned in every transfer
	typedef logic [31:0] addr_t;

	// Byte offset bits inside one word
	localparam int WORD_BYTES_LOG = 2;

	// Upstream single-word request
	// wdata is ignored for reads
	typedef struct packed {
		logic  write;
		addr_t addr;
		word_t wdata;
	} cpu_req_t;

	// Memory burst command, always one full line
	// Address is line aligned
	typedef struct packed {
		logic  write;
		addr_t addr;
	} mem_cmd_t;

	// Controller states
	// Free accepts a request, tag checks the lookup
	// Evict writes back a dirty victim, refill loads the line
	// The two response states hold the answer until it transfers
	typedef enum logic [2:0] {
		L3C_FREE,
		L3C_TAG,
		L3C_EVICT,
		L3C_REFILL,
		L3C_RSP_READ,
		L3C_RSP_WRITE
	} l3c_state_e;

endpackage

// ==== src/mem_burst_port.sv ====
`timescale 1ns/1ps
/*
 * Memory-side burst engine
 * Issues one line command, then streams write beats
 * or collects read beats, and signals completion
 */
module mem_burst_port import l3c_pkg::*; #(
	parameter int LINE_WORDS = 8,
	localparam int OFF_W = $clog2(LINE_WORDS)
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             burst_start,
	input  mem_cmd_t         burst_cmd,
	input  word_t            evict_word,
	output mem_cmd_t         mem_cmd,
	output logic             mem_cmd_valid,
	input  logic             mem_cmd_ready,
	output word_t            mem_wdata,
	output logic             mem_wlast,
	output logic             mem_wvalid,
	input  logic             mem_wready,
	input  logic             mem_bvalid,
	output logic             mem_bready,
	input  word_t            mem_rdata,
	input  logic             mem_rlast,
	input  logic             mem_rvalid,
	output logic             mem_rready,
	output logic [OFF_W-1:0] beat_idx,
	output logic             beat_strobe,
	output word_t            beat_data,
	output logic             burst_done
);

	typedef enum logic [2:0] {
		BP_IDLE,
		BP_CMD,
		BP_WDATA,
		BP_WRESP,
		BP_RDATA
	} bp_state_e;

	bp_state_e        state;
	mem_cmd_t         cmd_q;
	logic [OFF_W-1:0] beat_cnt;
	logic             done_q;
	logic             w_fire;
	logic             r_fire;
	logic             last_wbeat;

	// Command held from start until the memory takes it
	assign mem_cmd       = cmd_q;
	assign mem_cmd_valid = (state == BP_CMD);

	// Write beats straight from the store output
	assign mem_wvalid = (state == BP_WDATA);
	assign mem_wdata  = evict_word;
	assign last_wbeat = (beat_cnt == OFF_W'(LINE_WORDS - 1));
	assign mem_wlast  = mem_wvalid & last_wbeat;
	assign w_fire     = mem_wvalid & mem_wready;

	assign mem_bready = (state == BP_WRESP);
	assign mem_rready = (state == BP_RDATA);
	assign r_fire     = mem_rready & mem_rvalid;

	// During writeback point one beat ahead on a transfer,
	// since the store read takes one cycle
	assign beat_idx    = w_fire ? beat_cnt + OFF_W'(1) : beat_cnt;
	assign beat_strobe = r_fire;
	assign beat_data   = mem_rdata;
	assign burst_done  = done_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= BP_IDLE;
			beat_cnt <= '0;
			done_q   <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				BP_IDLE: begin
					if (burst_start) begin
						state    <= BP_CMD;
						beat_cnt <= '0;
					end
				end
				BP_CMD: begin
					if (mem_cmd_ready)
						state <= cmd_q.write ? BP_WDATA : BP_RDATA;
				end
				BP_WDATA: begin
					if (w_fire) begin
						beat_cnt <= beat_cnt + OFF_W'(1);
						if (last_wbeat)
							state <= BP_WRESP;
					end
				end
				BP_WRESP: begin
					// Writeback counts as done once memory acknowledges it
					if (mem_bvalid) begin
						state  <= BP_IDLE;
						done_q <= 1'b1;
					end
				end
				BP_RDATA: begin
					if (r_fire) begin
						beat_cnt <= beat_cnt + OFF_W'(1);
						if (mem_rlast) begin
							state  <= BP_IDLE;
							done_q <= 1'b1;
						end
					end
				end
				default: state <= BP_IDLE;
			endcase
		end
	end

	// Command payload, captured on start
	always_ff @(posedge clk) begin
		if (burst_start && (state == BP_IDLE))
			cmd_q <= burst_cmd;
	end

endmodule

// ==== cache_core/l3c_store.sv ====
`timescale 1ns/1ps
/*
 * Cache storage
 * Tag array with valid and dirty bits
 * Four-bank data array and the hit comparison
 */
module l3c_store import l3c_pkg::*; #(
	parameter int LINE_WORDS = 8,
	parameter int SETS       = 16,
	localparam int OFF_W = $clog2(LINE_WORDS),
	localparam int IDX_W = $clog2(SETS),
	localparam int TAG_W = 32 - WORD_BYTES_LOG - OFF_W - IDX_W
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [IDX_W-1:0] lookup_index,
	input  logic [OFF_W-1:0] word_sel,
	input  logic [TAG_W-1:0] tag_in,
	input  logic             store_wr,
	input  word_t            store_wdata,
	input  logic             fill_tag,
	input  logic             set_dirty,
	output logic             hit,
	output logic             victim_valid,
	output logic             victim_dirty,
	output logic [TAG_W-1:0] victim_tag,
	output word_t            rd_word
);

	localparam int BANKS      = 4;
	localparam int BANK_SEL_W = $clog2(BANKS);
	localparam int BANK_DEPTH = SETS * LINE_WORDS / BANKS;
	localparam int BANK_AW    = IDX_W + OFF_W - BANK_SEL_W;

	typedef logic [TAG_W-1:0] tag_t;

	tag_t                  tag_mem [SETS];
	tag_t                  tag_r;
	logic [SETS-1:0]       valid_bits;
	logic [SETS-1:0]       dirty_bits;
	logic                  valid_r;
	logic                  dirty_r;
	logic [IDX_W+OFF_W-1:0] line_word;
	logic [BANK_AW-1:0]    bank_addr;
	logic [BANK_SEL_W-1:0] bank_sel;
	logic [BANK_SEL_W-1:0] bank_sel_q;
	word_t                 bank_rd [BANKS];

	// Low offset bits pick the bank, the rest address inside it
	assign line_word = {lookup_index, word_sel};
	assign bank_sel  = word_sel[BANK_SEL_W-1:0];
	assign bank_addr = line_word[IDX_W+OFF_W-1:BANK_SEL_W];

	// Tag array, read every cycle with old data on a same-edge write
	always_ff @(posedge clk) begin
		if (fill_tag)
			tag_mem[lookup_index] <= tag_in;
		tag_r <= tag_mem[lookup_index];
	end

	// Line state, cleared on reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_bits <= '0;
			dirty_bits <= '0;
			valid_r    <= 1'b0;
			dirty_r    <= 1'b0;
		end else begin
			// A fresh line from memory is clean
			if (fill_tag) begin
				valid_bits[lookup_index] <= 1'b1;
				dirty_bits[lookup_index] <= 1'b0;
			end else if (set_dirty) begin
				dirty_bits[lookup_index] <= 1'b1;
			end
			valid_r <= valid_bits[lookup_index];
			dirty_r <= dirty_bits[lookup_index];
		end
	end

	for (genvar b = 0; b < BANKS; b++) begin : g_bank
		word_t bank_mem [BANK_DEPTH];

		always_ff @(posedge clk) begin
			if (store_wr && (bank_sel == BANK_SEL_W'(b)))
				bank_mem[bank_addr] <= store_wdata;
			bank_rd[b] <= bank_mem[bank_addr];
		end
	end

	// Bank select follows the read by one cycle
	always_ff @(posedge clk)
		bank_sel_q <= bank_sel;

	assign rd_word = bank_rd[bank_sel_q];

	assign hit          = valid_r & (tag_r == tag_in);
	assign victim_valid = valid_r;
	assign victim_dirty = dirty_r;
	assign victim_tag   = tag_r;

endmodule

// ==== cache_core/l3c_ctrl.sv ====
`timescale 1ns/1ps
/*
 * Blocking cache controller
 * Request latch and lookup FSM
 * Hit responses, dirty eviction and line refill sequencing
 */
module l3c_ctrl import l3c_pkg::*; #(
	parameter int LINE_WORDS = 8,
	parameter int SETS       = 16,
	localparam int OFF_W = $clog2(LINE_WORDS),
	localparam int IDX_W = $clog2(SETS),
	localparam int TAG_W = 32 - WORD_BYTES_LOG - OFF_W - IDX_W
) (
	input  logic             clk,
	input  logic             rst_n,
	input  cpu_req_t         req,
	input  logic             req_valid,
	output logic             req_ready,
	output word_t            rsp_data,
	output logic             rsp_valid,
	input  logic             rsp_ready,
	input  logic             hit,
	input  logic             victim_valid,
	input  logic             victim_dirty,
	input  logic [TAG_W-1:0] victim_tag,
	input  word_t            rd_word,
	input  logic [OFF_W-1:0] beat_idx,
	input  logic             beat_strobe,
	input  word_t            beat_data,
	input  logic             burst_done,
	output logic [IDX_W-1:0] lookup_index,
	output logic [OFF_W-1:0] word_sel,
	output logic [TAG_W-1:0] lookup_tag,
	output logic             store_wr,
	output word_t            store_wdata,
	output logic             fill_tag,
	output logic             set_dirty,
	output logic             burst_start,
	output mem_cmd_t         burst_cmd
);

	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [IDX_W-1:0] index_t;
	typedef logic [OFF_W-1:0] offset_t;

	l3c_state_e state;
	cpu_req_t   req_q;
	word_t      rsp_data_q;
	logic       rsp_valid_q;
	logic       req_fire;
	logic       rsp_fire;
	logic       rsp_first;
	logic       need_evict;
	tag_t       req_tag;
	index_t     req_index;
	index_t     new_index;
	offset_t    req_offset;
	addr_t      fill_addr;
	addr_t      evict_addr;

	// Address fields of the held request
	assign req_tag    = req_q.addr[31 -: TAG_W];
	assign req_index  = req_q.addr[WORD_BYTES_LOG + OFF_W +: IDX_W];
	assign req_offset = req_q.addr[WORD_BYTES_LOG +: OFF_W];
	// Index of the incoming request, looked up while still free
	assign new_index  = req.addr[WORD_BYTES_LOG + OFF_W +: IDX_W];

	// Line aligned burst addresses
	assign fill_addr  = {req_tag, req_index, {(OFF_W + WORD_BYTES_LOG){1'b0}}};
	assign evict_addr = {victim_tag, req_index, {(OFF_W + WORD_BYTES_LOG){1'b0}}};

	assign req_ready = (state == L3C_FREE);
	assign req_fire  = req_valid & req_ready;
	assign rsp_fire  = rsp_valid_q & rsp_ready;
	// First cycle in a response state, before rsp_valid rises
	assign rsp_first = ((state == L3C_RSP_READ) | (state == L3C_RSP_WRITE)) & ~rsp_valid_q;
	// Only modified lines go back to memory
	assign need_evict = victim_valid & victim_dirty;

	assign rsp_valid = rsp_valid_q;
	assign rsp_data  = rsp_data_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= L3C_FREE;
			rsp_valid_q <= 1'b0;
		end else begin
			case (state)
				L3C_FREE: begin
					if (req_fire)
						state <= L3C_TAG;
				end
				L3C_TAG: begin
					// Registered tag and state bits are valid here
					if (hit)
						state <= req_q.write ? L3C_RSP_WRITE : L3C_RSP_READ;
					else if (need_evict)
						state <= L3C_EVICT;
					else
						state <= L3C_REFILL;
				end
				L3C_EVICT: begin
					if (burst_done)
						state <= L3C_REFILL;
				end
				L3C_REFILL: begin
					// Look up again, this time it hits
					if (burst_done)
						state <= L3C_TAG;
				end
				L3C_RSP_READ, L3C_RSP_WRITE: begin
					if (rsp_fire)
						state <= L3C_FREE;
				end
				default: state <= L3C_FREE;
			endcase
			// Response held until the upstream takes it
			if (rsp_first)
				rsp_valid_q <= 1'b1;
			else if (rsp_fire)
				rsp_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (req_fire)
			req_q <= req;
		// Read word arrives from the store one cycle after the tag state
		if (rsp_first)
			rsp_data_q <= (state == L3C_RSP_WRITE) ? req_q.wdata : rd_word;
	end

	always_comb begin
		lookup_index = (state == L3C_FREE) ? new_index : req_index;
		// Bursts walk the line, everything else targets the request word
		if ((state == L3C_EVICT) || (state == L3C_REFILL))
			word_sel = beat_idx;
		else
			word_sel = req_offset;
	end

	assign lookup_tag = req_tag;

	// Refill beats and the write hit are the only store updates
	assign fill_tag    = (state == L3C_REFILL) & beat_strobe;
	assign set_dirty   = (state == L3C_RSP_WRITE) & rsp_first;
	assign store_wr    = fill_tag | set_dirty;
	assign store_wdata = (state == L3C_REFILL) ? beat_data : req_q.wdata;

	// Miss starts either writeback or refill; writeback chains into refill
	assign burst_start     = ((state == L3C_TAG) & ~hit) | ((state == L3C_EVICT) & burst_done);
	assign burst_cmd.write = (state == L3C_TAG) & need_evict;
	assign burst_cmd.addr  = burst_cmd.write ? evict_addr : fill_addr;

endmodule

// ==== src/l3c_top.sv ====
`timescale 1ns/1ps
/*
 * Cache slice top level
 * Connects the controller, the tag and data storage
 * and the memory-side burst engine
 */
module l3c_top import l3c_pkg::*; #(
	parameter int LINE_WORDS = 8,
	parameter int SETS       = 16,
	localparam int OFF_W = $clog2(LINE_WORDS),
	localparam int IDX_W = $clog2(SETS),
	localparam int TAG_W = 32 - WORD_BYTES_LOG - OFF_W - IDX_W
) (
	input  logic     clk,
	input  logic     rst_n,
	// Upstream request and response
	input  cpu_req_t req,
	input  logic     req_valid,
	output logic     req_ready,
	output word_t    rsp_data,
	output logic     rsp_valid,
	input  logic     rsp_ready,
	// Memory command channel
	output mem_cmd_t mem_cmd,
	output logic     mem_cmd_valid,
	input  logic     mem_cmd_ready,
	// Memory write data and write response
	output word_t    mem_wdata,
	output logic     mem_wlast,
	output logic     mem_wvalid,
	input  logic     mem_wready,
	input  logic     mem_bvalid,
	output logic     mem_bready,
	// Memory read data
	input  word_t    mem_rdata,
	input  logic     mem_rlast,
	input  logic     mem_rvalid,
	output logic     mem_rready
);

	// Storage lookup and update
	logic [IDX_W-1:0] lookup_index;
	logic [OFF_W-1:0] word_sel;
	logic [TAG_W-1:0] lookup_tag;
	logic             store_wr;
	word_t            store_wdata;
	logic             fill_tag;
	logic             set_dirty;
	logic             hit;
	logic             victim_valid;
	logic             victim_dirty;
	logic [TAG_W-1:0] victim_tag;
	word_t            rd_word;

	// Burst engine control and beat tracking
	logic             burst_start;
	mem_cmd_t         burst_cmd;
	logic [OFF_W-1:0] beat_idx;
	logic             beat_strobe;
	word_t            beat_data;
	logic             burst_done;

	l3c_ctrl #(
		.LINE_WORDS(LINE_WORDS),
		.SETS      (SETS)
	) l3c_ctrl_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (req),
		.req_valid   (req_valid),
		.req_ready   (req_ready),
		.rsp_data    (rsp_data),
		.rsp_valid   (rsp_valid),
		.rsp_ready   (rsp_ready),
		.hit         (hit),
		.victim_valid(victim_valid),
		.victim_dirty(victim_dirty),
		.victim_tag  (victim_tag),
		.rd_word     (rd_word),
		.beat_idx    (beat_idx),
		.beat_strobe (beat_strobe),
		.beat_data   (beat_data),
		.burst_done  (burst_done),
		.lookup_index(lookup_index),
		.word_sel    (word_sel),
		.lookup_tag  (lookup_tag),
		.store_wr    (store_wr),
		.store_wdata (store_wdata),
		.fill_tag    (fill_tag),
		.set_dirty   (set_dirty),
		.burst_start (burst_start),
		.burst_cmd   (burst_cmd)
	);

	l3c_store #(
		.LINE_WORDS(LINE_WORDS),
		.SETS      (SETS)
	) l3c_store_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.lookup_index(lookup_index),
		.word_sel    (word_sel),
		.tag_in      (lookup_tag),
		.store_wr    (store_wr),
		.store_wdata (store_wdata),
		.fill_tag    (fill_tag),
		.set_dirty   (set_dirty),
		.hit         (hit),
		.victim_valid(victim_valid),
		.victim_dirty(victim_dirty),
		.victim_tag  (victim_tag),
		.rd_word     (rd_word)
	);

	// The store output doubles as the eviction data stream
	mem_burst_port #(
		.LINE_WORDS(LINE_WORDS)
	) mem_burst_port_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.burst_start  (burst_start),
		.burst_cmd    (burst_cmd),
		.evict_word   (rd_word),
		.mem_cmd      (mem_cmd),
		.mem_cmd_valid(mem_cmd_valid),
		.mem_cmd_ready(mem_cmd_ready),
		.mem_wdata    (mem_wdata),
		.mem_wlast    (mem_wlast),
		.mem_wvalid   (mem_wvalid),
		.mem_wready   (mem_wready),
		.mem_bvalid   (mem_bvalid),
		.mem_bready   (mem_bready),
		.mem_rdata    (mem_rdata),
		.mem_rlast    (mem_rlast),
		.mem_rvalid   (mem_rvalid),
		.mem_rready   (mem_rready),
		.beat_idx     (beat_idx),
		.beat_strobe  (beat_strobe),
		.beat_data    (beat_data),
		.burst_done   (burst_done)
	);

endmodule

// ==== test/l3c_properties.sv ====
`timescale 1ns/1ps
/*
 * Concurrent checks bound into the cache top level
 * Burst length and last marker, valid hold, reset values
 */
module l3c_properties import l3c_pkg::*; #(
	parameter int LINE_WORDS = 8
) (
	input logic     clk,
	input logic     rst_n,
	input logic     rsp_valid,
	input logic     rsp_ready,
	input word_t    rsp_data,
	input mem_cmd_t mem_cmd,
	input logic     mem_cmd_valid,
	input logic     mem_cmd_ready,
	input word_t    mem_wdata,
	input logic     mem_wlast,
	input logic     mem_wvalid,
	input logic     mem_wready,
	input logic     mem_bready,
	input logic     mem_rready,
	input logic     mem_rvalid,
	input logic     mem_rlast
);

	int w_beats;
	int r_beats;
	// Number of assertion failures so far
	int fail_count = 0;

	// Beat counters per burst
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			w_beats <= 0;
			r_beats <= 0;
		end else begin
			if (mem_wvalid && mem_wready)
				w_beats <= mem_wlast ? 0 : w_beats + 1;
			if (mem_rvalid && mem_rready)
				r_beats <= mem_rlast ? 0 : r_beats + 1;
		end
	end

	a_wlast: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_wvalid && mem_wready) |-> (mem_wlast == (w_beats == LINE_WORDS - 1)))
		else begin
			fail_count++;
			$error("write burst length or last marker wrong");
		end

	a_rlast: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_rvalid && mem_rready) |-> (mem_rlast == (r_beats == LINE_WORDS - 1)))
		else begin
			fail_count++;
			$error("read burst length or last marker wrong");
		end

	a_cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_cmd_valid && !mem_cmd_ready) |=> (mem_cmd_valid && $stable(mem_cmd)))
		else begin
			fail_count++;
			$error("command dropped before transfer");
		end

	a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_wvalid && !mem_wready) |=> (mem_wvalid && $stable(mem_wdata)))
		else begin
			fail_count++;
			$error("write beat dropped before transfer");
		end

	a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_data)))
		else begin
			fail_count++;
			$error("response dropped before transfer");
		end

	// First edge after reset release
	a_reset: assert property (@(posedge clk) $rose(rst_n) |->
		!(rsp_valid || mem_cmd_valid || mem_wvalid || mem_bready || mem_rready))
		else begin
			fail_count++;
			$error("handshake output high right after reset");
		end

endmodule

// ==== test/tb_l3c.sv ====
`timescale 1ns/1ps
/*
 * Testbench for the cache slice
 * Clock, reset, vector reader, reference tag model
 * Memory model with random stalls, compare task, watchdog
 */
module tb_l3c import l3c_pkg::*;;

	localparam int LINE_WORDS = 8;
	localparam int SETS       = 16;
	localparam int OFF_W      = $clog2(LINE_WORDS);
	localparam int IDX_W      = $clog2(SETS);
	localparam int LINE_SH    = OFF_W + WORD_BYTES_LOG;
	localparam int TAG_W      = 32 - LINE_SH - IDX_W;

	logic clk;
	logic rst_n;
	cpu_req_t req;
	logic req_valid, req_ready, rsp_valid, rsp_ready;
	word_t rsp_data;
	mem_cmd_t mem_cmd;
	logic mem_cmd_valid, mem_cmd_ready;
	word_t mem_wdata, mem_rdata;
	logic mem_wlast, mem_wvalid, mem_wready, mem_bvalid, mem_bready;
	logic mem_rlast, mem_rvalid, mem_rready;

	integer seed = 32'hf46a_5348;

	// Vectors
	string v_name [$];
	logic  v_write [$];
	addr_t v_addr [$];
	word_t v_wdata [$];
	word_t v_exp [$];
	logic  vectors_ready = 1'b0;

	// Memory model state
	word_t mem_store [addr_t];
	int    rd_cmds = 0;
	int    wr_cmds = 0;
	addr_t last_rd_addr, last_wr_addr, w_base, r_base;
	int    w_cnt, r_cnt;
	logic  r_active = 1'b0;
	logic  b_pend = 1'b0;
	logic  r_took = 1'b0;

	// Reference tag state
	logic             ref_valid [SETS];
	logic             ref_dirty [SETS];
	logic [TAG_W-1:0] ref_tag [SETS];

	l3c_top #(.LINE_WORDS(LINE_WORDS), .SETS(SETS)) l3c_top_inst (.*);

	bind l3c_top l3c_properties #(.LINE_WORDS(LINE_WORDS)) l3c_properties_inst (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check(input string test, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
			stop_with_failure($sformatf("mismatch %s: expected %h, actual %h", test, exp, act));
	endtask

	function automatic word_t mem_word(input addr_t a);
		if (mem_store.exists(a))
			return mem_store[a];
		return a ^ 32'h5a5a_0000;
	endfunction

	// Memory side: sample on the rising edge, drive on the falling edge
	initial begin
		mem_cmd_ready = 1'b0;
		mem_wready    = 1'b0;
		mem_bvalid    = 1'b0;
		mem_rvalid    = 1'b0;
		mem_rlast     = 1'b0;
		mem_rdata     = '0;
		forever begin
			@(posedge clk);
			r_took = 1'b0;
			if (mem_cmd_valid && mem_cmd_ready) begin
				if (mem_cmd.write) begin
					wr_cmds++;
					last_wr_addr = mem_cmd.addr;
					w_base = mem_cmd.addr;
					w_cnt = 0;
				end else begin
					rd_cmds++;
					last_rd_addr = mem_cmd.addr;
					r_base = mem_cmd.addr;
					r_cnt = 0;
					r_active = 1'b1;
				end
			end
			if (mem_wvalid && mem_wready) begin
				mem_store[w_base + addr_t'(4 * w_cnt)] = mem_wdata;
				if (mem_wlast)
					b_pend = 1'b1;
				w_cnt++;
			end
			if (mem_bvalid && mem_bready)
				b_pend = 1'b0;
			if (mem_rvalid && mem_rready) begin
				r_took = 1'b1;
				r_cnt++;
				if (r_cnt == LINE_WORDS)
					r_active = 1'b0;
			end
			@(negedge clk);
			mem_cmd_ready = ($random(seed) & 3) != 0;
			mem_wready    = ($random(seed) & 3) != 0;
			if (!b_pend)
				mem_bvalid = 1'b0;
			else if (!mem_bvalid)
				mem_bvalid = ($random(seed) & 1) != 0;
			if (!r_active) begin
				mem_rvalid = 1'b0;
				mem_rlast  = 1'b0;
			end else if (!mem_rvalid || r_took) begin
				mem_rvalid = ($random(seed) & 3) != 0;
				mem_rdata  = mem_word(r_base + addr_t'(4 * r_cnt));
				mem_rlast  = (r_cnt == LINE_WORDS - 1);
			end
		end
	end

	task automatic load_vectors();
		integer fd;
		integer n;
		string line, nm, op;
		logic [31:0] a, d, e;
		fd = $fopen("test/l3c_vectors.txt", "r");
		if (fd == 0)
			stop_with_failure("cannot open the vector file test/l3c_vectors.txt");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() < 2 || line[0] == 8'h23)
				continue;
			n = $sscanf(line, "%s %s %h %h %h", nm, op, a, d, e);
			if (n == 5) begin
				v_name.push_back(nm);
				v_write.push_back(op == "W");
				v_addr.push_back(a);
				v_wdata.push_back(d);
				v_exp.push_back(e);
			end
		end
		$fclose(fd);
		if (v_name.size() == 0)
			stop_with_failure("vector file holds no vectors");
	endtask

	task automatic run_vector(input int i);
		int rd0, wr0, exp_rd, exp_wr;
		int idx;
		int lat;
		logic [TAG_W-1:0] tag;
		addr_t line_addr, victim_addr;
		word_t first_data;
		logic seen, done;
		idx = int'(v_addr[i][LINE_SH +: IDX_W]);
		tag = v_addr[i][31 -: TAG_W];
		line_addr = {v_addr[i][31:LINE_SH], {LINE_SH{1'b0}}};
		victim_addr = {ref_tag[idx], v_addr[i][LINE_SH +: IDX_W], {LINE_SH{1'b0}}};
		// Direct mapped, only dirty victims are written back
		exp_rd = 0;
		exp_wr = 0;
		if (!(ref_valid[idx] && ref_tag[idx] == tag)) begin
			exp_rd = 1;
			exp_wr = (ref_valid[idx] && ref_dirty[idx]) ? 1 : 0;
			ref_valid[idx] = 1'b1;
			ref_dirty[idx] = 1'b0;
			ref_tag[idx] = tag;
		end
		if (v_write[i])
			ref_dirty[idx] = 1'b1;
		rd0 = rd_cmds;
		wr0 = wr_cmds;
		@(negedge clk);
		req.write = v_write[i];
		req.addr  = v_addr[i];
		req.wdata = v_wdata[i];
		req_valid = 1'b1;
		while (!req_ready)
			@(negedge clk);
		@(negedge clk);
		req_valid = 0;
		seen = 1'b0;
		done = 1'b0;
		first_data = '0;
		// Cycles counted from the accepting edge
		lat = 0;
		while (!done) begin
			if (rsp_valid) begin
				if (!seen) begin
					seen = 1'b1;
					first_data = rsp_data;
					// A hit answers two cycles after acceptance
					if (exp_rd == 0)
						check({v_name[i], " hit latency"}, 2, lat);
				end else begin
					check({v_name[i], " held rsp_data"}, first_data, rsp_data);
				end
				if (req_ready)
					stop_with_failure({v_name[i], ": req_ready high while a response waits"});
			end
			rsp_ready = ($random(seed) & 1) != 0;
			if (rsp_valid && rsp_ready)
				done = 1'b1;
			if (!seen)
				lat++;
			@(negedge clk);
		end
		rsp_ready = 1'b0;
		check({v_name[i], " rsp_data"}, v_exp[i], first_data);
		check({v_name[i], " read bursts"}, exp_rd, rd_cmds - rd0);
		check({v_name[i], " write bursts"}, exp_wr, wr_cmds - wr0);
		if (exp_rd != 0)
			check({v_name[i], " refill address"}, line_addr, last_rd_addr);
		if (exp_wr != 0)
			check({v_name[i], " writeback address"}, victim_addr, last_wr_addr);
	endtask

	// Watchdog sized from the vector count
	initial begin
		wait (vectors_ready);
		repeat (16 + v_name.size() * (4 * LINE_WORDS + 40))
			@(posedge clk);
		stop_with_failure("timeout: the DUT stopped answering requests");
	end

	// Bound assertions count their failures
	initial begin
		forever begin
			@(negedge clk);
			if (l3c_top_inst.l3c_properties_inst.fail_count != 0)
				stop_with_failure("a bound assertion on the DUT failed");
		end
	end

	initial begin
		rst_n = 1'b0;
		req = '0;
		req_valid = 1'b0;
		rsp_ready = 1'b0;
		for (int s = 0; s < SETS; s++) begin
			ref_valid[s] = 1'b0;
			ref_dirty[s] = 1'b0;
			ref_tag[s] = '0;
		end
		load_vectors();
		vectors_ready = 1'b1;
		repeat (16)
			@(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check("after reset req_ready", 1, 32'(req_ready));
		check("after reset rsp_valid", 0, 32'(rsp_valid));
		for (int i = 0; i < v_name.size(); i++)
			run_vector(i);
		repeat (4)
			@(negedge clk);
		if (l3c_top_inst.l3c_properties_inst.fail_count != 0) begin
			stop_with_failure("a bound assertion on the DUT failed");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

// ==== flist.f ====
common/l3c_pkg.sv
src/mem_burst_port.sv
cache_core/l3c_store.sv
cache_core/l3c_ctrl.sv
src/l3c_top.sv
test/l3c_properties.sv
test/tb_l3c.sv

// ==== Makefile ====
# Verilator build for the cache slice testbench

VERILATOR ?= verilator
TOP       ?= tb_l3c
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

$(BUILD_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== test/l3c_vectors.txt ====
# name op(R/W) byte_addr(hex) wdata(hex) expected_rsp(hex)
# Unwritten memory reads as addr ^ 5a5a0000, a write answers with its own data
rd_miss      R 00000100 00000000 5a5a0100
wr_hit       W 00000104 deadbeef deadbeef
rd_back      R 00000104 00000000 deadbeef
rd_neighbor  R 00000108 00000000 5a5a0108
conflict_rd  R 00000304 00000000 5a5a0304
reread_first R 00000104 00000000 deadbeef
clean_victim R 00000300 00000000 5a5a0300
w_set1       W 00000020 00000000 00000000
w_set1_data  W 00000020 12345678 12345678
w_conf1      W 0000103c cafef00d cafef00d
r_back1      R 00000020 00000000 12345678
r_back2      R 0000103c 00000000 cafef00d
r_set2       R 00000040 00000000 5a5a0040
r_set2b      R 0000005c 00000000 5a5a005c
w_set3       W 00000060 11112222 11112222
w_set3b      W 0000007c 33334444 33334444
r_set3       R 00000060 00000000 11112222
r_set3m      R 00000064 00000000 5a5a0064
evict3       R 00002060 00000000 5a5a2060
back3        R 0000007c 00000000 33334444
back3_lo     R 00000060 00000000 11112222
r_high       R 800001e0 00000000 da5a01e0
w_high       W 800001e4 a5a5a5a5 a5a5a5a5
r_high2      R 800001e4 00000000 a5a5a5a5
r_high3      R 800001fc 00000000 da5a01fc
r_low_alias  R 000001e4 00000000 5a5a01e4
r_high4      R 800001e4 00000000 a5a5a5a5
